//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_lsu_top -f vlog.f -o sim_lsu
./obj_dir/sim_lsu | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- source/lsu_bus_fsm.sv
`timescale 1ns/1ps

module lsu_bus_fsm #(
	parameter int ID_WIDTH   = lsu_pkg::ID_WIDTH,
	parameter int DATA_WIDTH = lsu_pkg::DATA_WIDTH,
	parameter int BUS_WIDTH  = lsu_pkg::BUS_WIDTH
) (
	input  logic                 clock,
	input  logic                 reset,
	input  lsu_pkg::lsu_req_t    stage_req,
	input  logic                 stage_valid,
	input  lsu_pkg::lane_plan_t  plan,
	input  logic                 aw_ready,
	input  logic                 w_ready,
	input  logic                 b_valid,
	input  logic [ID_WIDTH-1:0]  b_id,
	input  logic                 ar_ready,
	input  logic                 r_valid,
	input  logic [ID_WIDTH-1:0]  r_id,
	output lsu_pkg::bus_addr_t   aw,
	output logic                 aw_valid,
	output lsu_pkg::bus_wdata_t  w,
	output logic                 w_valid,
	output logic                 b_ready,
	output lsu_pkg::bus_addr_t   ar,
	output logic                 ar_valid,
	output logic                 r_ready,
	output logic                 beat_accept,
	output logic                 second_beat,
	output logic                 op_done,
	output logic                 store_done
);

	import lsu_pkg::*;

	localparam int HALVES = BUS_WIDTH / DATA_WIDTH;

	typedef enum logic [2:0] {
		IDLE,
		ADDR,
		WDATA,
		RESP,
		NEXT
	} bus_state_e;

	bus_state_e          state;
	bus_state_e          state_next;
	logic [ID_WIDTH-1:0] id_count;
	logic [ID_WIDTH-1:0] beat_id;
	logic                is_load;
	logic                is_store;
	logic                resp_ok;
	logic                last_beat;
	logic [3:0]          beat_strb;
	bus_addr_t           beat_req;

	assign is_load  = stage_req.op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
	assign is_store = stage_req.op inside {OP_SW, OP_SH, OP_SB};

	// only a response carrying our ID counts
	assign resp_ok = is_store ? (b_valid && b_id == beat_id)
	                          : (r_valid && r_id == beat_id);

	assign last_beat = second_beat || !plan.split;

	always_comb begin
		state_next  = state;
		op_done     = 1'b0;
		beat_accept = 1'b0;
		case (state)
			IDLE: begin
				if (stage_valid) begin
					if (is_load || is_store) begin
						state_next = ADDR;
					end else begin
						// nothing to move on the bus
						op_done = 1'b1;
					end
				end
			end
			ADDR: begin
				if (is_store && aw_ready) begin
					state_next = WDATA;
				end else if (is_load && ar_ready) begin
					state_next = RESP;
				end
			end
			WDATA: begin
				if (w_ready) begin
					state_next = RESP;
				end
			end
			RESP: begin
				if (resp_ok) begin
					beat_accept = 1'b1;
					if (last_beat) begin
						op_done    = 1'b1;
						state_next = IDLE;
					end else begin
						state_next = NEXT;
					end
				end
			end
			NEXT: begin
				state_next = ADDR;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= IDLE;
			id_count    <= '0;
			second_beat <= 1'b0;
		end else begin
			state    <= state_next;
			id_count <= id_count + 1'b1;
			if (op_done) begin
				second_beat <= 1'b0;
			end else if (state == NEXT) begin
				second_beat <= 1'b1;
			end
		end
	end

	// fresh ID each time an address goes out
	always_ff @(posedge clock) begin
		if ((state == IDLE && state_next == ADDR) || state == NEXT) begin
			beat_id <= id_count;
		end
	end

	assign beat_req.id   = beat_id;
	assign beat_req.addr = second_beat ? plan.second_addr : plan.first_addr;
	assign beat_strb     = second_beat ? plan.second_strb : plan.first_strb;

	assign aw       = beat_req;
	assign ar       = beat_req;
	assign aw_valid = (state == ADDR) && is_store;
	assign ar_valid = (state == ADDR) && is_load;

	// same word on every half, slave picks by address bit 2
	assign w.data  = {HALVES{stage_req.data}};
	assign w.strb  = {HALVES{beat_strb}};
	assign w_valid = (state == WDATA);

	assign b_ready = (state == RESP) && is_store;
	assign r_ready = (state == RESP) && is_load;

	assign store_done = op_done && is_store;

endmodule

//--- source/lsu_lane_planner.sv
`timescale 1ns/1ps

module lsu_lane_planner #(
	parameter int ADDR_WIDTH = lsu_pkg::ADDR_WIDTH
) (
	input  lsu_pkg::lsu_req_t   stage_req,
	output lsu_pkg::lane_plan_t plan
);

	import lsu_pkg::*;

	logic [3:0]            access_mask;
	logic [1:0]            offset;
	logic [7:0]            lanes;
	logic [ADDR_WIDTH-1:0] word_addr;

	// bytes touched, before moving to the offset
	always_comb begin
		case (stage_req.op)
			OP_LW, OP_SW: begin
				access_mask = 4'b1111;
			end
			OP_LH, OP_LHU, OP_SH: begin
				access_mask = 4'b0011;
			end
			OP_LB, OP_LBU, OP_SB: begin
				access_mask = 4'b0001;
			end
			default: begin
				access_mask = 4'b0000;
			end
		endcase
	end

	assign offset = stage_req.addr[1:0];

	// upper nibble holds whatever spills past the word boundary
	assign lanes = {4'b0000, access_mask} << offset;

	assign word_addr = {stage_req.addr[ADDR_WIDTH-1:2], 2'b00};

	always_comb begin
		plan.first_addr  = word_addr;
		plan.second_addr = word_addr + ADDR_WIDTH'(4);
		plan.first_strb  = lanes[3:0];
		plan.second_strb = lanes[7:4];
		// e.g. LW at offset 1, or LH at offset 3
		plan.split       = |lanes[7:4];
	end

endmodule

//--- source/lsu_load_merge.sv
`timescale 1ns/1ps

module lsu_load_merge #(
	parameter int DATA_WIDTH = lsu_pkg::DATA_WIDTH,
	parameter int BUS_WIDTH  = lsu_pkg::BUS_WIDTH,
	parameter int REG_WIDTH  = lsu_pkg::REG_WIDTH
) (
	input  logic                 clock,
	input  logic                 reset,
	input  lsu_pkg::lsu_req_t    stage_req,
	input  lsu_pkg::lane_plan_t  plan,
	input  lsu_pkg::bus_rdata_t  r,
	input  logic                 beat_accept,
	input  logic                 second_beat,
	input  logic                 op_done,
	output lsu_pkg::wb_t         wb,
	output logic                 wb_valid
);

	import lsu_pkg::*;

	localparam int BYTES = DATA_WIDTH / 8;

	logic                    is_load;
	logic                    half_sel;
	logic                    capture;
	logic                    first_valid;
	logic [DATA_WIDTH-1:0]   beat_word;
	logic [DATA_WIDTH-1:0]   first_word;
	logic [DATA_WIDTH-1:0]   first_src;
	logic [DATA_WIDTH-1:0]   joined;
	logic [DATA_WIDTH-1:0]   aligned;
	logic [DATA_WIDTH-1:0]   ext;
	logic [2*DATA_WIDTH-1:0] doubled;

	assign is_load = stage_req.op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};

	// bus half that carries the word of this beat
	assign half_sel  = second_beat ? plan.second_addr[2] : plan.first_addr[2];
	assign beat_word = r.data[DATA_WIDTH*half_sel +: DATA_WIDTH];

	assign capture = beat_accept && is_load && !second_beat && plan.split;

	always_ff @(posedge clock) begin
		if (capture) begin
			first_word <= beat_word;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			first_valid <= 1'b0;
		end else if (op_done) begin
			first_valid <= 1'b0;
		end else if (capture) begin
			first_valid <= 1'b1;
		end
	end

	assign first_src = first_valid ? first_word : beat_word;

	always_comb begin
		for (int i = 0; i < BYTES; i++) begin
			if (plan.first_strb[i]) begin
				joined[8*i +: 8] = first_src[8*i +: 8];
			end else if (plan.second_strb[i]) begin
				joined[8*i +: 8] = beat_word[8*i +: 8];
			end else begin
				joined[8*i +: 8] = 8'h00;
			end
		end
	end

	// rotate right by the byte offset
	assign doubled = {joined, joined} >> (8 * stage_req.addr[1:0]);
	assign aligned = doubled[DATA_WIDTH-1:0];

	always_comb begin
		case (stage_req.op)
			OP_LH:   ext = {{(DATA_WIDTH-16){aligned[15]}}, aligned[15:0]};
			OP_LHU:  ext = {{(DATA_WIDTH-16){1'b0}}, aligned[15:0]};
			OP_LB:   ext = {{(DATA_WIDTH-8){aligned[7]}}, aligned[7:0]};
			OP_LBU:  ext = {{(DATA_WIDTH-8){1'b0}}, aligned[7:0]};
			default: ext = aligned;
		endcase
	end

	// x0 as target when there is no load
	assign wb.rd    = is_load ? stage_req.rd : {REG_WIDTH{1'b0}};
	assign wb.value = ext;
	assign wb_valid = op_done && is_load;

endmodule

//--- source/lsu_pkg.sv
package lsu_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int BUS_WIDTH  = 64;
	localparam int ID_WIDTH   = 4;
	localparam int REG_WIDTH  = 5;

	typedef enum logic [3:0] {
		OP_NONE,
		OP_LW,
		OP_LH,
		OP_LHU,
		OP_LB,
		OP_LBU,
		OP_SW,
		OP_SH,
		OP_SB
	} mem_op_e;

	typedef struct packed {
		mem_op_e                op;
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
		logic [REG_WIDTH-1:0]  rd;
	} lsu_req_t;

	// two word transfers at most, one strobe bit per byte of the word
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] first_addr;
		logic [ADDR_WIDTH-1:0] second_addr;
		logic [3:0]            first_strb;
		logic [3:0]            second_strb;
		logic                  split;
	} lane_plan_t;

	typedef struct packed {
		logic [ID_WIDTH-1:0]   id;
		logic [ADDR_WIDTH-1:0] addr;
	} bus_addr_t;

	typedef struct packed {
		logic [BUS_WIDTH-1:0]   data;
		logic [BUS_WIDTH/8-1:0] strb;
	} bus_wdata_t;

	typedef struct packed {
		logic [ID_WIDTH-1:0]  id;
		logic [BUS_WIDTH-1:0] data;
	} bus_rdata_t;

	typedef struct packed {
		logic [REG_WIDTH-1:0]  rd;
		logic [DATA_WIDTH-1:0] value;
	} wb_t;

endpackage

//--- source/lsu_request_stage.sv
`timescale 1ns/1ps

module lsu_request_stage (
	input  logic             clock,
	input  logic             reset,
	input  lsu_pkg::lsu_req_t req,
	input  logic             req_valid,
	input  logic             op_done,
	output logic             allowin,
	output lsu_pkg::lsu_req_t stage_req,
	output logic             stage_valid
);

	// empty stage, or the held operation retires this cycle
	assign allowin = !stage_valid || op_done;

	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else if (allowin) begin
			stage_valid <= req_valid;
		end
	end

	// payload only moves on an accepted request
	always_ff @(posedge clock) begin
		if (allowin && req_valid) begin
			stage_req <= req;
		end
	end

endmodule

//--- source/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
	parameter int ADDR_WIDTH = lsu_pkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = lsu_pkg::DATA_WIDTH,
	parameter int BUS_WIDTH  = lsu_pkg::BUS_WIDTH,
	parameter int ID_WIDTH   = lsu_pkg::ID_WIDTH,
	parameter int REG_WIDTH  = lsu_pkg::REG_WIDTH
) (
	input  logic                 clock,
	input  logic                 reset,
	input  lsu_pkg::lsu_req_t    req,
	input  logic                 req_valid,
	output logic                 allowin,
	output lsu_pkg::wb_t         wb,
	output logic                 wb_valid,
	output logic                 store_done,
	output lsu_pkg::bus_addr_t   aw,
	output logic                 aw_valid,
	input  logic                 aw_ready,
	output lsu_pkg::bus_wdata_t  w,
	output logic                 w_valid,
	input  logic                 w_ready,
	input  logic                 b_valid,
	input  logic [ID_WIDTH-1:0]  b_id,
	output logic                 b_ready,
	output lsu_pkg::bus_addr_t   ar,
	output logic                 ar_valid,
	input  logic                 ar_ready,
	input  lsu_pkg::bus_rdata_t  r,
	input  logic                 r_valid,
	output logic                 r_ready
);

	import lsu_pkg::*;

	lsu_req_t   stage_req;
	lane_plan_t plan;
	logic       stage_valid;
	logic       op_done;
	logic       beat_accept;
	logic       second_beat;

	lsu_request_stage request_stage_inst (
		.clock       (clock),
		.reset       (reset),
		.req         (req),
		.req_valid   (req_valid),
		.op_done     (op_done),
		.allowin     (allowin),
		.stage_req   (stage_req),
		.stage_valid (stage_valid)
	);

	lsu_lane_planner #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) lane_planner_inst (
		.stage_req (stage_req),
		.plan      (plan)
	);

	lsu_bus_fsm #(
		.ID_WIDTH   (ID_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.BUS_WIDTH  (BUS_WIDTH)
	) bus_fsm_inst (
		.clock       (clock),
		.reset       (reset),
		.stage_req   (stage_req),
		.stage_valid (stage_valid),
		.plan        (plan),
		.aw_ready    (aw_ready),
		.w_ready     (w_ready),
		.b_valid     (b_valid),
		.b_id        (b_id),
		.ar_ready    (ar_ready),
		.r_valid     (r_valid),
		.r_id        (r.id),
		.aw          (aw),
		.aw_valid    (aw_valid),
		.w           (w),
		.w_valid     (w_valid),
		.b_ready     (b_ready),
		.ar          (ar),
		.ar_valid    (ar_valid),
		.r_ready     (r_ready),
		.beat_accept (beat_accept),
		.second_beat (second_beat),
		.op_done     (op_done),
		.store_done  (store_done)
	);

	lsu_load_merge #(
		.DATA_WIDTH (DATA_WIDTH),
		.BUS_WIDTH  (BUS_WIDTH),
		.REG_WIDTH  (REG_WIDTH)
	) load_merge_inst (
		.clock       (clock),
		.reset       (reset),
		.stage_req   (stage_req),
		.plan        (plan),
		.r           (r),
		.beat_accept (beat_accept),
		.second_beat (second_beat),
		.op_done     (op_done),
		.wb          (wb),
		.wb_valid    (wb_valid)
	);

endmodule

//--- verification/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
	input  logic                          clock,
	input  logic                          reset,
	input  lsu_pkg::bus_addr_t            aw,
	input  logic                          aw_valid,
	output logic                          aw_ready = 1'b0,
	input  lsu_pkg::bus_wdata_t           w,
	input  logic                          w_valid,
	output logic                          w_ready = 1'b0,
	output logic                          b_valid = 1'b0,
	output logic [lsu_pkg::ID_WIDTH-1:0]  b_id = '0,
	input  logic                          b_ready,
	input  lsu_pkg::bus_addr_t            ar,
	input  logic                          ar_valid,
	output logic                          ar_ready = 1'b0,
	output lsu_pkg::bus_rdata_t           r = '0,
	output logic                          r_valid = 1'b0,
	input  logic                          r_ready
);

	import lsu_pkg::*;

	integer     seed = 44;
	logic [7:0] mem [0:255];
	logic [1:0] aw_wait;
	logic [1:0] w_wait;
	logic [1:0] b_wait;
	logic [1:0] ar_wait;
	logic [1:0] r_wait;
	bus_addr_t  wr_hold;
	bus_addr_t  rd_hold;
	logic       b_pending;
	logic       r_pending;

	always @(posedge clock) begin
		if (reset) begin
			aw_ready  <= 1'b0;
			w_ready   <= 1'b0;
			ar_ready  <= 1'b0;
			b_valid   <= 1'b0;
			r_valid   <= 1'b0;
			b_pending <= 1'b0;
			r_pending <= 1'b0;
			aw_wait   <= 2'($random(seed));
			w_wait    <= 2'($random(seed));
			ar_wait   <= 2'($random(seed));
			// fill byte is the inverted address
			for (int i = 0; i < 256; i++) begin
				mem[i] <= ~8'(i);
			end
		end else begin
			if (aw_valid && aw_ready) begin
				wr_hold  <= aw;
				aw_ready <= 1'b0;
				aw_wait  <= 2'($random(seed));
			end else if (aw_valid) begin
				if (aw_wait == 2'd0) begin
					aw_ready <= 1'b1;
				end else begin
					aw_wait <= aw_wait - 2'd1;
				end
			end
			// lanes of the half picked by address bit 2
			if (w_valid && w_ready) begin
				w_ready   <= 1'b0;
				w_wait    <= 2'($random(seed));
				b_pending <= 1'b1;
				b_wait    <= 2'($random(seed));
				for (int i = 0; i < 4; i++) begin
					if (w.strb[4*int'(wr_hold.addr[2]) + i]) begin
						mem[8'(wr_hold.addr[7:0] + 8'(i))] <=
							w.data[8*(4*int'(wr_hold.addr[2]) + i) +: 8];
					end
				end
			end else if (w_valid) begin
				if (w_wait == 2'd0) begin
					w_ready <= 1'b1;
				end else begin
					w_wait <= w_wait - 2'd1;
				end
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
			end else if (b_pending) begin
				if (b_wait == 2'd0) begin
					b_valid   <= 1'b1;
					b_id      <= wr_hold.id;
					b_pending <= 1'b0;
				end else begin
					b_wait <= b_wait - 2'd1;
				end
			end
			if (ar_valid && ar_ready) begin
				rd_hold   <= ar;
				ar_ready  <= 1'b0;
				ar_wait   <= 2'($random(seed));
				r_pending <= 1'b1;
				r_wait    <= 2'($random(seed));
			end else if (ar_valid) begin
				if (ar_wait == 2'd0) begin
					ar_ready <= 1'b1;
				end else begin
					ar_wait <= ar_wait - 2'd1;
				end
			end
			// whole doubleword goes back, the DUT picks its half
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
			end else if (r_pending) begin
				if (r_wait == 2'd0) begin
					r_valid   <= 1'b1;
					r.id      <= rd_hold.id;
					r_pending <= 1'b0;
					for (int j = 0; j < 8; j++) begin
						r.data[8*j +: 8] <= mem[8'({rd_hold.addr[7:3], 3'b000} + 8'(j))];
					end
				end else begin
					r_wait <= r_wait - 2'd1;
				end
			end
		end
	end

endmodule

//--- verification/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top;

	import lsu_pkg::*;

	localparam int TIMEOUT = 200;

	typedef struct packed {
		mem_op_e     op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [4:0]  rd;
		logic [31:0] expected;
	} entry_t;

	logic                clock;
	logic                reset;
	lsu_req_t            req;
	logic                req_valid;
	logic                allowin;
	wb_t                 wb;
	logic                wb_valid;
	logic                store_done;
	bus_addr_t           aw;
	logic                aw_valid;
	logic                aw_ready;
	bus_wdata_t          w;
	logic                w_valid;
	logic                w_ready;
	logic                b_valid;
	logic [ID_WIDTH-1:0] b_id;
	logic                b_ready;
	bus_addr_t           ar;
	logic                ar_valid;
	logic                ar_ready;
	bus_rdata_t          r;
	logic                r_valid;
	logic                r_ready;

	entry_t     tests [$];
	logic [7:0] ref_mem [0:255];
	int         errors;
	int         passed;
	int         failed;
	bit         timed_out;
	bit         entry_ok;

	lsu_top lsu_top_inst (
		.clock      (clock),
		.reset      (reset),
		.req        (req),
		.req_valid  (req_valid),
		.allowin    (allowin),
		.wb         (wb),
		.wb_valid   (wb_valid),
		.store_done (store_done),
		.aw         (aw),
		.aw_valid   (aw_valid),
		.aw_ready   (aw_ready),
		.w          (w),
		.w_valid    (w_valid),
		.w_ready    (w_ready),
		.b_valid    (b_valid),
		.b_id       (b_id),
		.b_ready    (b_ready),
		.ar         (ar),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.r          (r),
		.r_valid    (r_valid),
		.r_ready    (r_ready)
	);

	axi_mem_model mem_model_inst (
		.clock    (clock),
		.reset    (reset),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.b_valid  (b_valid),
		.b_id     (b_id),
		.b_ready  (b_ready),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic add_entry(input mem_op_e op, input logic [31:0] addr,
			input logic [31:0] data, input logic [31:0] expected);
		entry_t e;
		e.op       = op;
		e.addr     = addr;
		e.data     = data;
		e.rd       = 5'(tests.size() % 31 + 1);
		e.expected = expected;
		tests.push_back(e);
	endtask

	task automatic build_table();
		add_entry(OP_SW,  32'h10, 32'hdeadbeef, 32'h0);
		add_entry(OP_LW,  32'h10, 32'h0, 32'hdeadbeef);
		add_entry(OP_SW,  32'h14, 32'hcafef00d, 32'h0);
		add_entry(OP_LW,  32'h14, 32'h0, 32'hcafef00d);
		add_entry(OP_LW,  32'h10, 32'h0, 32'hdeadbeef);
		// split words leave the neighbour bytes at their fill value
		add_entry(OP_SW,  32'h21, 32'h11223344, 32'h0);
		add_entry(OP_LBU, 32'h20, 32'h0, 32'h000000df);
		add_entry(OP_LBU, 32'h25, 32'h0, 32'h000000da);
		add_entry(OP_LBU, 32'h21, 32'h0, 32'h00000044);
		add_entry(OP_LBU, 32'h24, 32'h0, 32'h00000011);
		add_entry(OP_LW,  32'h21, 32'h0, 32'h11223344);
		add_entry(OP_SW,  32'h32, 32'h55667788, 32'h0);
		add_entry(OP_LBU, 32'h31, 32'h0, 32'h000000ce);
		add_entry(OP_LBU, 32'h36, 32'h0, 32'h000000c9);
		add_entry(OP_LW,  32'h32, 32'h0, 32'h55667788);
		add_entry(OP_LHU, 32'h33, 32'h0, 32'h00006677);
		add_entry(OP_SW,  32'h43, 32'h99aabbcc, 32'h0);
		add_entry(OP_LBU, 32'h42, 32'h0, 32'h000000bd);
		add_entry(OP_LBU, 32'h47, 32'h0, 32'h000000b8);
		add_entry(OP_LW,  32'h43, 32'h0, 32'h99aabbcc);
		// sign and zero extension
		add_entry(OP_SW,  32'h50, 32'h80f17f85, 32'h0);
		add_entry(OP_LB,  32'h50, 32'h0, 32'hffffff85);
		add_entry(OP_LBU, 32'h50, 32'h0, 32'h00000085);
		add_entry(OP_LB,  32'h51, 32'h0, 32'h0000007f);
		add_entry(OP_LH,  32'h52, 32'h0, 32'hffff80f1);
		add_entry(OP_LHU, 32'h52, 32'h0, 32'h000080f1);
		add_entry(OP_LH,  32'h50, 32'h0, 32'h00007f85);
		// halfword across the word boundary
		add_entry(OP_SH,  32'h63, 32'h0000a1b2, 32'h0);
		add_entry(OP_LH,  32'h63, 32'h0, 32'hffffa1b2);
		add_entry(OP_LHU, 32'h63, 32'h0, 32'h0000a1b2);
		add_entry(OP_LBU, 32'h62, 32'h0, 32'h0000009d);
		add_entry(OP_LBU, 32'h65, 32'h0, 32'h0000009a);
		add_entry(OP_SB,  32'h66, 32'h000000ee, 32'h0);
		add_entry(OP_LB,  32'h66, 32'h0, 32'hffffffee);
		add_entry(OP_LBU, 32'h66, 32'h0, 32'h000000ee);
	endtask

	function automatic logic is_store_op(mem_op_e op);
		return op inside {OP_SW, OP_SH, OP_SB};
	endfunction

	function automatic int access_bytes(mem_op_e op);
		case (op)
			OP_LW, OP_SW: return 4;
			OP_LH, OP_LHU, OP_SH: return 2;
			default: return 1;
		endcase
	endfunction

	// the unit expects store data already sitting in its byte lanes
	function automatic logic [31:0] lane_data(logic [31:0] value, logic [1:0] offset);
		logic [63:0] twice;
		twice = {value, value} << (8 * offset);
		return twice[63:32];
	endfunction

	task automatic store_reference(input mem_op_e op, input logic [31:0] addr,
			input logic [31:0] value);
		for (int i = 0; i < access_bytes(op); i++) begin
			ref_mem[8'(addr + 32'(i))] = value[8*i +: 8];
		end
	endtask

	// little-endian read from the reference bytes
	function automatic logic [31:0] expected_load(mem_op_e op, logic [31:0] addr);
		logic [31:0] word;
		for (int i = 0; i < 4; i++) begin
			word[8*i +: 8] = ref_mem[8'(addr + 32'(i))];
		end
		case (op)
			OP_LB: return {{24{word[7]}}, word[7:0]};
			OP_LBU: return {24'h0, word[7:0]};
			OP_LH: return {{16{word[15]}}, word[15:0]};
			OP_LHU: return {16'h0, word[15:0]};
			default: return word;
		endcase
	endfunction

	task automatic report_error(input string msg);
		$display("[FAIL] %0d ns: %s", $time, msg);
		errors++;
		entry_ok = 1'b0;
	endtask

	task automatic wait_allowin(input int idx);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!allowin && cycles < TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!allowin) begin
			$display("timeout: the unit never accepted entry %0d", idx);
			timed_out = 1'b1;
		end
	endtask

	task automatic apply_entry(input int idx);
		entry_t  e;
		mem_op_e op;
		int      cycles;
		bit      done;
		e = tests[idx];
		op = e.op;
		entry_ok = 1'b1;
		req.op = op;
		req.addr = e.addr;
		req.rd = e.rd;
		req.data = is_store_op(op) ? lane_data(e.data, e.addr[1:0]) : e.data;
		req_valid = 1'b1;
		wait_allowin(idx);
		if (timed_out) begin
			return;
		end
		@(posedge clock);
		#5;
		req_valid = 1'b0;
		cycles = 0;
		done = 1'b0;
		// allowin must stay low until the result pulse
		while (!done && cycles < TIMEOUT) begin
			@(negedge clock);
			cycles++;
			if (wb_valid || store_done) begin
				done = 1'b1;
			end else if (allowin) begin
				report_error($sformatf("entry %0d allowin high while busy", idx));
			end
		end
		if (!done) begin
			$display("timeout: entry %0d never finished", idx);
			timed_out = 1'b1;
			return;
		end
		if (is_store_op(op)) begin
			if (!store_done || wb_valid) begin
				report_error($sformatf("entry %0d store gave no store_done pulse", idx));
			end
			store_reference(op, e.addr, e.data);
		end else begin
			if (!wb_valid || store_done) begin
				report_error($sformatf("entry %0d load gave no wb_valid pulse", idx));
			end
			if (wb.rd !== e.rd) begin
				report_error($sformatf("entry %0d rd %0d, expected %0d", idx, wb.rd, e.rd));
			end
			if (wb.value !== e.expected) begin
				report_error($sformatf("entry %0d got %h, expected %h",
					idx, wb.value, e.expected));
			end
			if (wb.value !== expected_load(op, e.addr)) begin
				report_error($sformatf("entry %0d got %h, reference memory has %h",
					idx, wb.value, expected_load(op, e.addr)));
			end
		end
		if (entry_ok) begin
			passed++;
		end else begin
			failed++;
		end
		$display("test %0d %s addr %h: %s", idx, op.name(), e.addr, entry_ok ? "ok" : "wrong");
		@(posedge clock);
		#5;
	endtask

	initial begin
		reset = 1'b1;
		req = '0;
		req_valid = 1'b0;
		errors = 0;
		passed = 0;
		failed = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = ~8'(i);
		end
		build_table();
		repeat (2) @(posedge clock);
		#5;
		reset = 1'b0;
		for (int i = 0; i < tests.size(); i++) begin
			if (!timed_out) begin
				apply_entry(i);
			end
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			tests.size(), passed, failed, errors);
		if (errors == 0 && failed == 0 && !timed_out && passed == tests.size()) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- vlog.f
source/lsu_pkg.sv
source/lsu_request_stage.sv
source/lsu_lane_planner.sv
source/lsu_bus_fsm.sv
source/lsu_load_merge.sv
source/lsu_top.sv
verification/axi_mem_model.sv
verification/tb_lsu_top.sv
